// ==== all.f ====
+incdir+include
src/frame_pkg.sv
src/video_timing.sv
src/grab_control.sv
src/luma_capture.sv
src/frame_store_port.sv
src/video_output.sv
src/frame_grabber_top.sv
verification/sram_model.sv
verification/tb_frame_grabber.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frame grabber testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_frame_grabber -o sim_frame_grabber
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_frame_grabber > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1

// ==== verification/tb_frame_grabber.sv ====
////////////////////////////////////////
// Directed testbench for the frame grabber
// Small raster of 16x8 active in 24x12 total
// Host answers every pixel_req one cycle later
////////////////////////////////////////
`timescale 1ns/100ps
`include "frame_params.svh"

module tb_frame_grabber;

    import frame_pkg::*;

    localparam int FRAME_CYCLES = 24 * 12;
    localparam int FRAME_PIX    = 16 * 8;
    localparam int WATCHDOG_NS  = 10 * FRAME_CYCLES * 40 * 2;

    logic                  iCLK;
    logic                  iRST_N;
    rgb_t                  rgb;
    logic                  draw;
    logic                  pixel_req;
    vga_t                  vga;
    sram_req_t             sram_req;
    logic [`FG_DATA_W-1:0] sram_rdata;
    int                    write_count;

    // Host and monitor state
    logic [31:0] lfsr_state;
    logic        use_random;
    int          req_count;
    logic        pix_valid;
    int          pix_idx;
    logic        shown_valid;
    rgb_t        shown_pix;
    int          shown_idx;
    logic [7:0]  exp_frame [0:FRAME_PIX-1];
    logic        replay_exp;
    logic        writes_allowed;
    int          capture_writes;
    int          errors;
    int          checks;
    int          tests;

    frame_grabber_top #(
        .H_SYNC (2), .H_BACK (3), .H_ACT (16), .H_TOTAL (24),
        .V_SYNC (1), .V_BACK (1), .V_ACT (8), .V_TOTAL (12)
    ) u_frame_grabber_top (
        .iCLK       (iCLK),
        .iRST_N     (iRST_N),
        .rgb        (rgb),
        .draw       (draw),
        .pixel_req  (pixel_req),
        .vga        (vga),
        .sram_req   (sram_req),
        .sram_rdata (sram_rdata)
    );

    sram_model u_sram_model (
        .iCLK        (iCLK),
        .sram_req    (sram_req),
        .sram_rdata  (sram_rdata),
        .write_count (write_count)
    );

    initial begin
        iCLK = 1'b0;
        forever #20 iCLK = ~iCLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run stopped by the watchdog, the tests did not complete in time");
        $display("Testbench failed");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [29:0] next_random();
        logic [29:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < 30; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[28:0], fb};
        end
        return val;
    endfunction

    function automatic logic [29:0] pattern_pixel(input int idx);
        return {10'(idx * 37), 10'(1023 - idx * 5), 10'((idx * 61) ^ 341)};
    endfunction

    function automatic logic [7:0] luma_of(input rgb_t p);
        int r;
        int g;
        int b;
        r = p.r[9:2];
        g = p.g[9:2];
        b = p.b[9:2];
        return 8'((`FG_LUMA_R * r + `FG_LUMA_G * g + `FG_LUMA_B * b) / `FG_LUMA_DIV);
    endfunction

    // Host answers a request one cycle later and remembers what it sent
    always @(posedge iCLK) begin
        shown_valid <= pix_valid;
        shown_pix   <= rgb;
        shown_idx   <= pix_idx;
        if (pixel_req) begin
            rgb       <= use_random ? next_random() : pattern_pixel(req_count % FRAME_PIX);
            pix_valid <= 1'b1;
            pix_idx   <= req_count % FRAME_PIX;
            req_count <= req_count + 1;
        end else begin
            pix_valid <= 1'b0;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic fail_note(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    // One clock of monitoring on the falling edge
    task automatic step_cycle();
        logic [7:0]  grey;
        logic [29:0] exp_col;
        @(negedge iCLK);
        check_value("vga.blank_n", vga.blank_n, vga.hsync & vga.vsync);
        if (!sram_req.we_n) begin
            if (!writes_allowed || !shown_valid) begin
                fail_note("SRAM write seen where no write was expected");
            end else begin
                // First write marks the start of a capture frame
                replay_exp = 1'b0;
                if (capture_writes == 0) begin
                    check_value("first_capture_addr", sram_req.addr, 0);
                end
                check_value("sram_req.addr", sram_req.addr, shown_idx);
                check_value("sram_req.wdata", sram_req.wdata, luma_of(shown_pix));
                exp_frame[shown_idx] = luma_of(shown_pix);
                capture_writes++;
            end
        end
        if (!shown_valid) begin
            exp_col = '0;
        end else if (replay_exp) begin
            grey = exp_frame[shown_idx];
            exp_col = {grey, 2'b00, grey, 2'b00, grey, 2'b00};
        end else begin
            exp_col = shown_pix;
        end
        check_value("vga.color", vga.color, exp_col);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_reset();
        int e0;
        e0 = errors;
        #1;
        check_value("pixel_req", pixel_req, 1'b0);
        check_value("sram_req.we_n", sram_req.we_n, 1'b1);
        check_value("vga", vga, '0);
        check_value("mode", u_frame_grabber_top.u_grab_control.mode, MODE_LIVE);
        report_test("test_reset", e0);
    endtask

    task automatic test_sync();
        int e0;
        int hs_low;
        int vs_low;
        int run;
        int cyc;
        int last_fall;
        e0 = errors;
        hs_low = 0;
        vs_low = 0;
        run = 0;
        cyc = 0;
        last_fall = -1;
        // Counters reach the pins through two register stages
        repeat (2) begin
            step_cycle();
        end
        repeat (FRAME_CYCLES) begin
            step_cycle();
            if (!vga.hsync) begin
                if (run == 0) begin
                    if (last_fall >= 0) begin
                        check_value("hsync_period", cyc - last_fall, 24);
                    end
                    last_fall = cyc;
                end
                hs_low++;
                run++;
            end else if (run != 0) begin
                check_value("hsync_low_run", run, 2);
                run = 0;
            end
            if (!vga.vsync) begin
                vs_low++;
            end
            cyc++;
        end
        check_value("hsync_low_per_frame", hs_low, 2 * 12);
        check_value("vsync_low_per_frame", vs_low, 24);
        report_test("test_sync", e0);
    endtask

    task automatic test_live();
        int e0;
        int shown;
        int run;
        e0 = errors;
        shown = 0;
        run = 0;
        repeat (2 * FRAME_CYCLES) begin
            step_cycle();
            if (shown_valid) begin
                shown++;
            end
            if (pixel_req) begin
                run++;
            end else if (run != 0) begin
                check_value("requests_per_line", run, 16);
                run = 0;
            end
        end
        check_value("live_pixels", shown, 2 * FRAME_PIX);
        report_test("test_live", e0);
    endtask

    // Arms a capture and waits for the whole frame to be written
    task automatic capture_frame(input string name);
        int e0;
        int cycles;
        int base;
        e0 = errors;
        base = write_count;
        capture_writes = 0;
        writes_allowed = 1'b1;
        @(posedge iCLK);
        draw <= 1'b1;
        step_cycle();
        @(posedge iCLK);
        draw <= 1'b0;
        cycles = 0;
        while (capture_writes < FRAME_PIX && cycles < 3 * FRAME_CYCLES) begin
            step_cycle();
            cycles++;
        end
        writes_allowed = 1'b0;
        replay_exp = 1'b1;
        if (capture_writes < FRAME_PIX) begin
            fail_note("Capture did not write a whole frame in time");
        end
        // Last write lands in the SRAM on the next rising edge
        step_cycle();
        check_value("sram_writes", write_count - base, FRAME_PIX);
        report_test(name, e0);
    endtask

    task automatic test_replay(input string name, input int frames);
        int e0;
        int base;
        e0 = errors;
        base = write_count;
        use_random = 1'b1;
        repeat (frames * FRAME_CYCLES) begin
            step_cycle();
        end
        check_value("replay_writes", write_count - base, 0);
        report_test(name, e0);
    endtask

    initial begin
        iRST_N         <= 1'b0;
        rgb            <= '0;
        draw           <= 1'b0;
        lfsr_state     = 32'h930b_a798;
        use_random     = 1'b1;
        req_count      = 0;
        pix_valid      = 1'b0;
        pix_idx        = 0;
        replay_exp     = 1'b0;
        writes_allowed = 1'b0;
        capture_writes = 0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        test_reset();
        repeat (3) @(posedge iCLK);
        iRST_N <= 1'b1;
        test_sync();
        test_live();
        use_random = 1'b0;
        capture_frame("test_capture");
        test_replay("test_replay", 2);
        capture_frame("test_recapture");
        test_replay("test_replay_new", 1);
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verification/sram_model.sv ====
////////////////////////////////////////
// Asynchronous SRAM model, one word per address
// Read is combinational, write lands on the clock edge
// Only the low address bits select a word
////////////////////////////////////////
`timescale 1ns/100ps
`include "frame_params.svh"

module sram_model #(
    parameter int DEPTH_W = 10
) (
    input  logic                  iCLK,
    input  frame_pkg::sram_req_t  sram_req,
    output logic [`FG_DATA_W-1:0] sram_rdata,
    output int                    write_count
);

    logic [`FG_DATA_W-1:0] mem [0:(1 << DEPTH_W)-1];

    // Fill depends on every address bit
    initial begin
        write_count = 0;
        for (int i = 0; i < (1 << DEPTH_W); i++) begin
            mem[i] = `FG_DATA_W'((i * 40503) ^ (i >> 3) ^ 16'ha5c3);
        end
    end

    assign sram_rdata = mem[sram_req.addr[DEPTH_W-1:0]];

    always @(posedge iCLK) begin
        if (!sram_req.we_n) begin
            mem[sram_req.addr[DEPTH_W-1:0]] <= sram_req.wdata;
            write_count <= write_count + 1;
        end
    end

endmodule

// ==== src/frame_grabber_top.sv ====
////////////////////////////////////////
// Frame grabber with SRAM frame store
// Host supplies a pixel the cycle after pixel_req
// No back pressure toward the host
// SRAM enables and data pad live on the board
////////////////////////////////////////
`timescale 1ns/100ps
`include "frame_params.svh"

module frame_grabber_top #(
    parameter int H_SYNC  = `FG_H_SYNC,
    parameter int H_BACK  = `FG_H_BACK,
    parameter int H_ACT   = `FG_H_ACT,
    parameter int H_TOTAL = `FG_H_TOTAL,
    parameter int V_SYNC  = `FG_V_SYNC,
    parameter int V_BACK  = `FG_V_BACK,
    parameter int V_ACT   = `FG_V_ACT,
    parameter int V_TOTAL = `FG_V_TOTAL
) (
    input  logic                  iCLK,
    input  logic                  iRST_N,
    input  frame_pkg::rgb_t       rgb,
    input  logic                  draw,
    output logic                  pixel_req,
    output frame_pkg::vga_t       vga,
    output frame_pkg::sram_req_t  sram_req,
    input  logic [`FG_DATA_W-1:0] sram_rdata
);

    import frame_pkg::*;

    sync_t      timing;
    logic       frame_start;
    grab_mode_t mode;
    sram_req_t  cap_req;

    video_timing #(
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .H_ACT   (H_ACT),
        .H_TOTAL (H_TOTAL),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .V_ACT   (V_ACT),
        .V_TOTAL (V_TOTAL)
    ) u_video_timing (
        .iCLK        (iCLK),
        .iRST_N      (iRST_N),
        .timing      (timing),
        .frame_start (frame_start),
        .pixel_req   (pixel_req)
    );

    grab_control u_grab_control (
        .iCLK        (iCLK),
        .iRST_N      (iRST_N),
        .draw        (draw),
        .frame_start (frame_start),
        .mode        (mode)
    );

    luma_capture #(
        .H_ACT (H_ACT)
    ) u_luma_capture (
        .iCLK    (iCLK),
        .iRST_N  (iRST_N),
        .mode    (mode),
        .timing  (timing),
        .rgb     (rgb),
        .cap_req (cap_req)
    );

    frame_store_port #(
        .H_ACT (H_ACT)
    ) u_frame_store_port (
        .iCLK      (iCLK),
        .iRST_N    (iRST_N),
        .mode      (mode),
        .pixel_req (pixel_req),
        .timing    (timing),
        .cap_req   (cap_req),
        .sram_req  (sram_req)
    );

    video_output u_video_output (
        .iCLK       (iCLK),
        .iRST_N     (iRST_N),
        .mode       (mode),
        .timing     (timing),
        .rgb        (rgb),
        .sram_rdata (sram_rdata),
        .vga        (vga)
    );

endmodule

// ==== src/video_output.sv ====
////////////////////////////////////////
// Registered VGA bundle
// Colour is forced to zero outside the window
// Replay grey is padded with two low zero bits
////////////////////////////////////////
`timescale 1ns/100ps
`include "frame_params.svh"

module video_output (
    input  logic                  iCLK,
    input  logic                  iRST_N,
    input  frame_pkg::grab_mode_t mode,
    input  frame_pkg::sync_t      timing,
    input  frame_pkg::rgb_t       rgb,
    input  logic [`FG_DATA_W-1:0] sram_rdata,
    output frame_pkg::vga_t       vga
);

    import frame_pkg::*;

    localparam int PAD_W = `FG_COLOR_W - `FG_LUMA_W;

    logic [`FG_COLOR_W-1:0] grey;
    rgb_t                   pix;

    always_comb begin
        grey = {sram_rdata[`FG_LUMA_W-1:0], {PAD_W{1'b0}}};
        if (!timing.pos.active) begin
            pix = '0;
        end else if (mode == MODE_REPLAY) begin
            pix.r = grey;
            pix.g = grey;
            pix.b = grey;
        end else begin
            // Live and capture both show the host pixel
            pix = rgb;
        end
    end

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            vga <= '0;
        end else begin
            vga.color   <= pix;
            vga.hsync   <= timing.hsync;
            vga.vsync   <= timing.vsync;
            vga.blank_n <= timing.hsync & timing.vsync;
        end
    end

endmodule

// ==== src/frame_store_port.sv ====
////////////////////////////////////////
// SRAM request select for capture and replay
// Read address is set one cycle ahead of the pixel
// SRAM read data must be valid in the same cycle
////////////////////////////////////////
`timescale 1ns/100ps
`include "frame_params.svh"

module frame_store_port #(
    parameter int H_ACT = `FG_H_ACT
) (
    input  logic                  iCLK,
    input  logic                  iRST_N,
    input  frame_pkg::grab_mode_t mode,
    input  logic                  pixel_req,
    input  frame_pkg::sync_t      timing,
    input  frame_pkg::sram_req_t  cap_req,
    output frame_pkg::sram_req_t  sram_req
);

    import frame_pkg::*;

    localparam int AW = `FG_ADDR_W;
    localparam logic [AW-1:0] COL_LAST  = AW'(H_ACT - 1);
    localparam logic [AW-1:0] LINE_STEP = AW'(H_ACT);

    logic [AW-1:0] col;
    logic [AW-1:0] row_base;
    logic [AW-1:0] rd_addr;

    // Line base plus column, restarted during vertical sync
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            col      <= '0;
            row_base <= '0;
            rd_addr  <= '0;
        end else if (!timing.vsync) begin
            col      <= '0;
            row_base <= '0;
        end else if ((mode == MODE_REPLAY) && pixel_req) begin
            rd_addr <= row_base + col;
            if (col == COL_LAST) begin
                col      <= '0;
                row_base <= row_base + LINE_STEP;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_comb begin
        if (mode == MODE_CAPTURE) begin
            sram_req = cap_req;
        end else begin
            sram_req.addr  = rd_addr;
            sram_req.wdata = '0;
            sram_req.we_n  = 1'b1;
        end
    end

endmodule

// ==== src/luma_capture.sv ====
////////////////////////////////////////
// RGB to luma for every active capture pixel
// Uses the top 8 bits of each channel
// Write strobe is low for one cycle per pixel
////////////////////////////////////////
`timescale 1ns/100ps
`include "frame_params.svh"

module luma_capture #(
    parameter int H_ACT = `FG_H_ACT
) (
    input  logic                  iCLK,
    input  logic                  iRST_N,
    input  frame_pkg::grab_mode_t mode,
    input  frame_pkg::sync_t      timing,
    input  frame_pkg::rgb_t       rgb,
    output frame_pkg::sram_req_t  cap_req
);

    import frame_pkg::*;

    localparam int SUM_W = 20;
    localparam int AW    = `FG_ADDR_W;
    localparam int LW    = `FG_LUMA_W;
    localparam int TOP   = `FG_COLOR_W - 1;
    localparam int PAD_W = `FG_DATA_W - `FG_LUMA_W;

    logic [SUM_W-1:0] weighted;
    logic [SUM_W-1:0] quotient;
    logic [AW-1:0]    lin_addr;
    logic             capture;
    logic [AW-1:0]    addr_q;
    logic [LW-1:0]    luma_q;
    logic             we_n_q;

    always_comb begin
        weighted = SUM_W'(`FG_LUMA_R) * SUM_W'(rgb.r[TOP -: LW])
                 + SUM_W'(`FG_LUMA_G) * SUM_W'(rgb.g[TOP -: LW])
                 + SUM_W'(`FG_LUMA_B) * SUM_W'(rgb.b[TOP -: LW]);
        quotient = weighted / SUM_W'(`FG_LUMA_DIV);
        // Row major, one word per pixel
        lin_addr = AW'(timing.pos.x) + AW'(timing.pos.y) * AW'(H_ACT);
        capture  = (mode == MODE_CAPTURE) && timing.pos.active;
    end

    always_ff @(posedge iCLK) begin
        if (capture) begin
            addr_q <= lin_addr;
            luma_q <= quotient[LW-1:0];
        end
    end

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            we_n_q <= 1'b1;
        end else begin
            we_n_q <= !capture;
        end
    end

    assign cap_req.addr  = addr_q;
    assign cap_req.wdata = {{PAD_W{1'b0}}, luma_q};
    assign cap_req.we_n  = we_n_q;

endmodule

// ==== src/grab_control.sv ====
////////////////////////////////////////
// Live, capture and replay sequencing
// Mode only changes on a frame start
// A draw pulse is held until the next frame start
////////////////////////////////////////
`timescale 1ns/100ps

module grab_control (
    input  logic                  iCLK,
    input  logic                  iRST_N,
    input  logic                  draw,
    input  logic                  frame_start,
    output frame_pkg::grab_mode_t mode
);

    import frame_pkg::*;

    logic armed;

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            armed <= 1'b0;
            mode  <= MODE_LIVE;
        end else begin
            // A new draw wins over the clear at a frame start
            if (draw) begin
                armed <= 1'b1;
            end else if (frame_start) begin
                armed <= 1'b0;
            end

            if (frame_start) begin
                if (armed) begin
                    mode <= MODE_CAPTURE;
                end else if (mode == MODE_CAPTURE) begin
                    mode <= MODE_REPLAY;
                end
            end
        end
    end

endmodule

// ==== src/video_timing.sv ====
////////////////////////////////////////
// Raster counters with registered sync and window
// Counters wrap at total minus one
// Vertical count steps at horizontal count zero
// Back porch sums must be at least 2
////////////////////////////////////////
`timescale 1ns/100ps
`include "frame_params.svh"

module video_timing #(
    parameter int H_SYNC  = `FG_H_SYNC,
    parameter int H_BACK  = `FG_H_BACK,
    parameter int H_ACT   = `FG_H_ACT,
    parameter int H_TOTAL = `FG_H_TOTAL,
    parameter int V_SYNC  = `FG_V_SYNC,
    parameter int V_BACK  = `FG_V_BACK,
    parameter int V_ACT   = `FG_V_ACT,
    parameter int V_TOTAL = `FG_V_TOTAL
) (
    input  logic             iCLK,
    input  logic             iRST_N,
    output frame_pkg::sync_t timing,
    output logic             frame_start,
    output logic             pixel_req
);

    localparam int CW = `FG_CNT_W;
    localparam logic [CW-1:0] X_START  = CW'(H_SYNC + H_BACK);
    localparam logic [CW-1:0] X_END    = CW'(H_SYNC + H_BACK + H_ACT);
    localparam logic [CW-1:0] Y_START  = CW'(V_SYNC + V_BACK);
    localparam logic [CW-1:0] Y_END    = CW'(V_SYNC + V_BACK + V_ACT);
    localparam logic [CW-1:0] H_LAST   = CW'(H_TOTAL - 1);
    localparam logic [CW-1:0] V_LAST   = CW'(V_TOTAL - 1);
    localparam logic [CW-1:0] HS_END   = CW'(H_SYNC);
    localparam logic [CW-1:0] VS_END   = CW'(V_SYNC);

    logic [CW-1:0] h_cnt;
    logic [CW-1:0] v_cnt;
    logic [CW-1:0] h_nxt;
    logic [CW-1:0] v_nxt;

    function automatic logic in_window(input logic [CW-1:0] h, input logic [CW-1:0] v);
        return (h >= X_START) && (h < X_END) && (v >= Y_START) && (v < Y_END);
    endfunction

    always_comb begin
        h_nxt = (h_cnt == H_LAST) ? '0 : h_cnt + 1'b1;
        v_nxt = v_cnt;
        if (h_cnt == '0) begin
            v_nxt = (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end
    end

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_nxt;
            v_cnt <= v_nxt;
        end
    end

    ////////////////////////////////////////
    // Registered outputs
    ////////////////////////////////////////
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            timing      <= '0;
            frame_start <= 1'b0;
            pixel_req   <= 1'b0;
        end else begin
            timing.hsync      <= (h_cnt >= HS_END);
            timing.vsync      <= (v_cnt >= VS_END);
            timing.pos.active <= in_window(h_cnt, v_cnt);
            timing.pos.x      <= h_cnt - X_START;
            timing.pos.y      <= v_cnt - Y_START;
            frame_start       <= (h_cnt == '0) && (v_cnt == '0);
            // Next counts give the request one cycle ahead of active
            pixel_req         <= in_window(h_nxt, v_nxt);
        end
    end

endmodule

// ==== src/frame_pkg.sv ====
////////////////////////////////////////
// Shared bundles for the frame grabber
// Sync levels are active low
// Pixel x and y are only valid while active is set
////////////////////////////////////////
`include "frame_params.svh"

package frame_pkg;

    typedef struct packed {
        logic [`FG_COLOR_W-1:0] r;
        logic [`FG_COLOR_W-1:0] g;
        logic [`FG_COLOR_W-1:0] b;
    } rgb_t;

    // Position inside the active window
    typedef struct packed {
        logic                 active;
        logic [`FG_CNT_W-1:0] x;
        logic [`FG_CNT_W-1:0] y;
    } pixel_pos_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        pixel_pos_t pos;
    } sync_t;

    typedef struct packed {
        logic [`FG_ADDR_W-1:0] addr;
        logic [`FG_DATA_W-1:0] wdata;
        logic                  we_n;
    } sram_req_t;

    typedef struct packed {
        rgb_t color;
        logic hsync;
        logic vsync;
        logic blank_n;
    } vga_t;

    typedef enum logic [1:0] {
        MODE_LIVE,
        MODE_CAPTURE,
        MODE_REPLAY
    } grab_mode_t;

endpackage

// ==== include/frame_params.svh ====
////////////////////////////////////////
// Timing and width constants for the grabber
// Default timing is SVGA 800x600, one pixel per clock
// One SRAM word holds one grey pixel
////////////////////////////////////////
`ifndef FRAME_PARAMS_SVH
`define FRAME_PARAMS_SVH

// Horizontal timing in pixels
`define FG_H_SYNC   128
`define FG_H_BACK   88
`define FG_H_ACT    800
`define FG_H_TOTAL  1056

// Vertical timing in lines
`define FG_V_SYNC   4
`define FG_V_BACK   23
`define FG_V_ACT    600
`define FG_V_TOTAL  628

// Data widths
`define FG_COLOR_W  10
`define FG_LUMA_W   8
`define FG_ADDR_W   20
`define FG_DATA_W   16
`define FG_CNT_W    13

// Luma weights, scaled by the divisor
`define FG_LUMA_R   299
`define FG_LUMA_G   587
`define FG_LUMA_B   114
`define FG_LUMA_DIV 1000

`endif
